/* design/cfg_link_pkg.sv */
/*
 * UART link configuration package
 * Frame setting types, negotiation packet bytes, the standard
 * configuration and the CPU register addresses
 */
package cfg_link_pkg;

    // ----------------------------------------
    // Frame settings
    // ----------------------------------------

    typedef enum logic [1:0] {
        DW_5BIT = 2'd0,
        DW_6BIT = 2'd1,
        DW_7BIT = 2'd2,
        DW_8BIT = 2'd3
    } data_width_e;

    // PAR_NONE2 behaves exactly like PAR_NONE
    typedef enum logic [1:0] {
        PAR_NONE  = 2'd0,
        PAR_EVEN  = 2'd1,
        PAR_ODD   = 2'd2,
        PAR_NONE2 = 2'd3
    } parity_mode_e;

    typedef struct packed {
        data_width_e  data_width;
        parity_mode_e parity_mode;
        logic [1:0]   stop_bits;
    } uart_cfg_t;

    // ----------------------------------------
    // Negotiation packets
    // ----------------------------------------

    typedef enum logic [1:0] {
        DATA_WIDTH_ID  = 2'd0,
        PARITY_MODE_ID = 2'd1,
        STOP_BITS_ID   = 2'd2,
        END_CONFIG_ID  = 2'd3
    } cfg_id_e;

    localparam logic [7:0] SYN_BYTE   = 8'h16;
    localparam logic [7:0] ACKN_BYTE  = 8'h06;
    localparam logic [3:0] CFG_MARKER = 4'hC;

    // Settings used after reset and whenever a negotiation fails
    localparam uart_cfg_t STD_CFG = '{data_width: DW_8BIT, parity_mode: PAR_NONE,
                                      stop_bits: 2'b00};

    // Marker in the upper nibble, field id and option below it
    function automatic logic [7:0] cfg_packet(cfg_id_e id, logic [1:0] option);
        return {CFG_MARKER, id, option};
    endfunction

    // ----------------------------------------
    // CPU register map
    // ----------------------------------------

    localparam logic [1:0] REG_CTRL    = 2'd0;
    localparam logic [1:0] REG_NEW_CFG = 2'd1;
    localparam logic [1:0] REG_CUR_CFG = 2'd2;
    localparam logic [1:0] REG_STATUS  = 2'd3;

endpackage

/* design/cfg_ctrl_if.sv */
/*
 * Link configuration control interface
 * Connects the register block to the negotiation sequencer
 */
interface cfg_ctrl_if;
    import cfg_link_pkg::*;

    // Requests and settings held by the register block
    logic      start_master;
    logic      slave_en;
    uart_cfg_t new_cfg;
    uart_cfg_t cur_cfg;

    // Results reported back by the sequencer
    logic      apply;
    uart_cfg_t apply_cfg;
    logic      busy;
    logic      cfg_error;
    logic      done;

    modport regs (
        output start_master, slave_en, new_cfg, cur_cfg,
        input  apply, apply_cfg, busy, cfg_error, done
    );

    modport seq (
        input  start_master, slave_en, new_cfg, cur_cfg,
        output apply, apply_cfg, busy, cfg_error, done
    );

endinterface

/* design/cfg_regs.sv */
/*
 * Link configuration register block
 * Wishbone classic slave holding the control bits, the requested
 * and active frame settings and the sticky status flags
 */
module cfg_regs (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  logic [1:0] wb_adr_i,
    input  logic [7:0] wb_dat_i,
    input  logic       parity_err_i,
    output logic [7:0] wb_dat_o,
    output logic       wb_ack_o,
    cfg_ctrl_if.regs   ctrl
);
    import cfg_link_pkg::*;

    logic       wb_req;
    logic       wb_wr;
    logic       ctrl_wr;
    logic [2:0] status_q;
    logic [2:0] status_set;
    logic [2:0] status_clr;
    logic [7:0] rd_data;

    // ----------------------------------------
    // Bus decode
    // ----------------------------------------

    // A request is only taken while no ack is out, so each access acks once
    assign wb_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wb_wr   = wb_req & wb_we_i;
    assign ctrl_wr = wb_wr && (wb_adr_i == REG_CTRL);

    // Status bits are error, parity error and done from bit 0 upward
    assign status_set = {ctrl.done, parity_err_i, ctrl.cfg_error};
    assign status_clr = (wb_wr && (wb_adr_i == REG_STATUS)) ? wb_dat_i[2:0] : 3'b000;

    always_comb begin
        case (wb_adr_i)
            REG_CTRL:    rd_data = {4'b0000, ctrl.busy, ctrl.slave_en, 2'b00};
            REG_NEW_CFG: rd_data = {2'b00, ctrl.new_cfg};
            REG_CUR_CFG: rd_data = {2'b00, ctrl.cur_cfg};
            default:     rd_data = {5'b00000, status_q};
        endcase
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o          <= 1'b0;
            ctrl.start_master <= 1'b0;
            ctrl.slave_en     <= 1'b0;
            ctrl.new_cfg      <= STD_CFG;
            ctrl.cur_cfg      <= STD_CFG;
            status_q          <= 3'b000;
        end else begin
            wb_ack_o <= wb_req;

            // Start is a single pulse toward the sequencer
            ctrl.start_master <= ctrl_wr & wb_dat_i[0];

            if (ctrl_wr) begin
                ctrl.slave_en <= wb_dat_i[2];
            end

            if (wb_wr && (wb_adr_i == REG_NEW_CFG)) begin
                ctrl.new_cfg <= uart_cfg_t'(wb_dat_i[5:0]);
            end

            // A finished negotiation wins over a set-standard request
            if (ctrl.apply) begin
                ctrl.cur_cfg <= ctrl.apply_cfg;
            end else if (ctrl_wr && wb_dat_i[1] && !ctrl.busy) begin
                ctrl.cur_cfg <= STD_CFG;
            end

            // New events take priority over a clear in the same cycle
            status_q <= (status_q & ~status_clr) | status_set;
        end
    end

    // Read data is captured with the request so it is valid with the ack
    always_ff @(posedge clk_i) begin
        if (wb_req) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

/* design/cfg_link_fsm.sv */
/*
 * Link configuration sequencer
 * Runs the master handshake (SYN, per-field packets, end packet) or
 * answers a remote master as slave, with timeout and retry fallback
 */
module cfg_link_fsm #(
    parameter int TIMEOUT_CYCLES = 1000,
    parameter int SYN_COUNT      = 3,
    parameter int MAX_ATTEMPTS   = 3
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       tx_ready_i,
    input  logic       rx_valid_i,
    input  logic [7:0] rx_data_i,
    output logic       tx_valid_o,
    output logic [7:0] tx_data_o,
    cfg_ctrl_if.seq    ctrl
);
    import cfg_link_pkg::*;

    localparam int TMR_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam int SYN_W = $clog2(SYN_COUNT + 1);
    localparam int ATT_W = $clog2(MAX_ATTEMPTS + 1);

    typedef enum logic [2:0] {
        IDLE, M_SYN, M_SYN_WAIT, M_PKT, M_ACK_WAIT, S_ACK, S_WAIT
    } state_e;

    state_e           state_q, state_d;
    logic [TMR_W-1:0] tmr_q;
    logic [SYN_W-1:0] syn_cnt_q, syn_cnt_d;
    logic [ATT_W-1:0] attempt_q, attempt_d;
    cfg_id_e          pkt_id_q, pkt_id_d;
    uart_cfg_t        shadow_q, shadow_d;
    logic             slv_end_q, slv_end_d;
    logic             wait_state, timeout, fail;
    logic             tx_done, rx_ack, rx_syn, rx_pkt;
    logic [1:0]       pkt_opt;

    // ----------------------------------------
    // Byte stream decode
    // ----------------------------------------

    assign tx_done = tx_valid_o & tx_ready_i;
    assign rx_ack  = rx_valid_i && (rx_data_i == ACKN_BYTE);
    assign rx_syn  = rx_valid_i && (rx_data_i == SYN_BYTE);
    assign rx_pkt  = rx_valid_i && (rx_data_i[7:4] == CFG_MARKER);

    // Only the states that wait for the remote side run the timer
    assign wait_state = (state_q == M_SYN_WAIT) || (state_q == M_ACK_WAIT) ||
                        (state_q == S_WAIT);
    assign timeout    = wait_state && (tmr_q == TMR_W'(TIMEOUT_CYCLES - 1));

    assign ctrl.busy = (state_q != IDLE);

    // Output byte depends on registered state only, so it holds under back-pressure
    assign tx_valid_o = (state_q == M_SYN) || (state_q == M_PKT) || (state_q == S_ACK);

    always_comb begin
        case (pkt_id_q)
            DATA_WIDTH_ID:  pkt_opt = ctrl.new_cfg.data_width;
            PARITY_MODE_ID: pkt_opt = ctrl.new_cfg.parity_mode;
            STOP_BITS_ID:   pkt_opt = ctrl.new_cfg.stop_bits;
            default:        pkt_opt = 2'b00;
        endcase
        case (state_q)
            M_PKT:   tx_data_o = cfg_packet(pkt_id_q, pkt_opt);
            S_ACK:   tx_data_o = ACKN_BYTE;
            default: tx_data_o = SYN_BYTE;
        endcase
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------

    always_comb begin
        state_d        = state_q;
        syn_cnt_d      = syn_cnt_q;
        attempt_d      = attempt_q;
        pkt_id_d       = pkt_id_q;
        shadow_d       = shadow_q;
        slv_end_d      = slv_end_q;
        fail           = 1'b0;
        ctrl.apply     = 1'b0;
        ctrl.apply_cfg = STD_CFG;
        ctrl.done      = 1'b0;
        ctrl.cfg_error = 1'b0;

        case (state_q)
            IDLE: begin
                if (ctrl.start_master) begin
                    state_d   = M_SYN;
                    syn_cnt_d = '0;
                    attempt_d = '0;
                end else if (ctrl.slave_en && rx_syn) begin
                    // Slave edits a copy of the active settings
                    state_d   = S_ACK;
                    shadow_d  = ctrl.cur_cfg;
                    slv_end_d = 1'b0;
                end
            end
            M_SYN: begin
                if (tx_done) begin
                    if (syn_cnt_q == SYN_W'(SYN_COUNT - 1)) begin
                        state_d   = M_SYN_WAIT;
                        syn_cnt_d = '0;
                    end else begin
                        syn_cnt_d = syn_cnt_q + 1'b1;
                    end
                end
            end
            M_SYN_WAIT: begin
                if (rx_ack) begin
                    state_d  = M_PKT;
                    pkt_id_d = DATA_WIDTH_ID;
                end else if (timeout) begin
                    // Retry the SYN burst until the attempts run out
                    if (attempt_q == ATT_W'(MAX_ATTEMPTS - 1)) begin
                        fail = 1'b1;
                    end else begin
                        attempt_d = attempt_q + 1'b1;
                        state_d   = M_SYN;
                    end
                end
            end
            M_PKT: begin
                if (tx_done) begin
                    state_d = M_ACK_WAIT;
                end
            end
            M_ACK_WAIT: begin
                if (rx_ack) begin
                    if (pkt_id_q == END_CONFIG_ID) begin
                        state_d        = IDLE;
                        ctrl.apply     = 1'b1;
                        ctrl.apply_cfg = ctrl.new_cfg;
                        ctrl.done      = 1'b1;
                    end else begin
                        state_d  = M_PKT;
                        pkt_id_d = cfg_id_e'(pkt_id_q + 1'b1);
                    end
                end else if (timeout) begin
                    fail = 1'b1;
                end
            end
            S_ACK: begin
                // The end packet is acknowledged before the settings take effect
                if (tx_done) begin
                    if (slv_end_q) begin
                        state_d        = IDLE;
                        ctrl.apply     = 1'b1;
                        ctrl.apply_cfg = shadow_q;
                        ctrl.done      = 1'b1;
                    end else begin
                        state_d = S_WAIT;
                    end
                end
            end
            S_WAIT: begin
                if (rx_pkt) begin
                    state_d = S_ACK;
                    case (cfg_id_e'(rx_data_i[3:2]))
                        DATA_WIDTH_ID:  shadow_d.data_width  = data_width_e'(rx_data_i[1:0]);
                        PARITY_MODE_ID: shadow_d.parity_mode = parity_mode_e'(rx_data_i[1:0]);
                        STOP_BITS_ID:   shadow_d.stop_bits   = rx_data_i[1:0];
                        default:        slv_end_d            = 1'b1;
                    endcase
                end else if (timeout) begin
                    fail = 1'b1;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // Any failed negotiation returns to the standard settings
        if (fail) begin
            state_d        = IDLE;
            ctrl.apply     = 1'b1;
            ctrl.apply_cfg = STD_CFG;
            ctrl.cfg_error = 1'b1;
        end
    end

    // ----------------------------------------
    // State registers
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            tmr_q     <= '0;
            syn_cnt_q <= '0;
            attempt_q <= '0;
            pkt_id_q  <= DATA_WIDTH_ID;
            slv_end_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            syn_cnt_q <= syn_cnt_d;
            attempt_q <= attempt_d;
            pkt_id_q  <= pkt_id_d;
            slv_end_q <= slv_end_d;
            // Timer restarts on every state change and idles outside wait states
            if ((state_d != state_q) || !wait_state) begin
                tmr_q <= '0;
            end else begin
                tmr_q <= tmr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        shadow_q <= shadow_d;
    end

endmodule

/* design/parity_checker.sv */
/*
 * Receive parity checker
 * Flags a received byte whose parity bit disagrees with the
 * active data width and parity mode
 */
module parity_checker (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  rx_valid_i,
    input  logic [7:0]            rx_data_i,
    input  logic                  rx_parity_i,
    input  cfg_link_pkg::uart_cfg_t cur_cfg_i,
    output logic                  parity_err_o
);
    import cfg_link_pkg::*;

    logic data_xor;
    logic expected;
    logic mismatch;

    always_comb begin
        // Only the bits inside the frame width count
        case (cur_cfg_i.data_width)
            DW_5BIT: data_xor = ^rx_data_i[4:0];
            DW_6BIT: data_xor = ^rx_data_i[5:0];
            DW_7BIT: data_xor = ^rx_data_i[6:0];
            default: data_xor = ^rx_data_i;
        endcase

        // Odd parity inverts the expected bit
        expected = data_xor ^ (cur_cfg_i.parity_mode == PAR_ODD);

        case (cur_cfg_i.parity_mode)
            PAR_EVEN, PAR_ODD: mismatch = (rx_parity_i != expected);
            default:           mismatch = 1'b0;
        endcase
    end

    // One pulse per bad byte, a cycle after it arrives
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            parity_err_o <= 1'b0;
        end else begin
            parity_err_o <= rx_valid_i & mismatch;
        end
    end

endmodule

/* design/cfg_link_top.sv */
/*
 * UART link configuration controller
 * Register block, negotiation sequencer and receive parity check
 */
module cfg_link_top #(
    parameter int TIMEOUT_CYCLES = 1000,
    parameter int SYN_COUNT      = 3,
    parameter int MAX_ATTEMPTS   = 3
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    // Wishbone classic slave
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  logic [1:0] wb_adr_i,
    input  logic [7:0] wb_dat_i,
    output logic [7:0] wb_dat_o,
    output logic       wb_ack_o,
    // Transmit byte stream
    input  logic       tx_ready_i,
    output logic       tx_valid_o,
    output logic [7:0] tx_data_o,
    // Receive byte stream
    input  logic       rx_valid_i,
    input  logic [7:0] rx_data_i,
    input  logic       rx_parity_i
);

    logic parity_err;

    cfg_ctrl_if ctrl_if ();

    cfg_regs cfg_regs_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .parity_err_i (parity_err),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .ctrl         (ctrl_if.regs)
    );

    cfg_link_fsm #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .SYN_COUNT      (SYN_COUNT),
        .MAX_ATTEMPTS   (MAX_ATTEMPTS)
    ) cfg_link_fsm_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .tx_ready_i (tx_ready_i),
        .rx_valid_i (rx_valid_i),
        .rx_data_i  (rx_data_i),
        .tx_valid_o (tx_valid_o),
        .tx_data_o  (tx_data_o),
        .ctrl       (ctrl_if.seq)
    );

    // Received bytes are judged against the settings currently in force
    parity_checker parity_checker_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rx_valid_i   (rx_valid_i),
        .rx_data_i    (rx_data_i),
        .rx_parity_i  (rx_parity_i),
        .cur_cfg_i    (ctrl_if.cur_cfg),
        .parity_err_o (parity_err)
    );

endmodule

/* verif/cfg_link_checker.sv */
/*
 * Link controller port assertions
 * Transmit hold under back-pressure, Wishbone ack shape, reset state
 */
module cfg_link_checker (
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       wb_cyc_i,
    input logic       wb_stb_i,
    input logic       wb_ack_o,
    input logic       tx_valid_o,
    input logic       tx_ready_i,
    input logic [7:0] tx_data_o
);

    // A stalled byte must not change before the transmitter takes it
    a_tx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tx_valid_o && !tx_ready_i) |=> $stable(tx_data_o))
        else $error("tx_data_o changed while held");

    a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o longer than one cycle");

    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o outside a bus cycle");

    a_tx_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !tx_valid_o)
        else $error("tx_valid_o high after reset");

endmodule

bind cfg_link_top cfg_link_checker cfg_link_checker_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_ack_o   (wb_ack_o),
    .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i),
    .tx_data_o  (tx_data_o)
);

/* verif/cfg_link_tb.sv */
/*
 * Link configuration controller testbench
 * Plays the CPU on Wishbone and the remote device on the byte streams
 * through master, slave, fallback and parity cases
 */
module cfg_link_tb;
    import cfg_link_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int WB_LIMIT       = 20;
    localparam int TX_LIMIT       = 1000;
    localparam int POLL_LIMIT     = 200;
    // 8-bit data, no parity, stop code 0, as the register reads it
    localparam logic [7:0] STD_BYTE = {2'b00, DW_8BIT, PAR_NONE, 2'b00};

    logic       clk_i;
    logic       rst_n_i;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    logic [1:0] wb_adr_i;
    logic [7:0] wb_dat_i;
    logic [7:0] wb_dat_o;
    logic       wb_ack_o;
    logic       tx_ready_i;
    logic       tx_valid_o;
    logic [7:0] tx_data_o;
    logic       rx_valid_i;
    logic [7:0] rx_data_i;
    logic       rx_parity_i;

    int          value_errs;
    int          other_errs;
    logic [31:0] lfsr_q;
    // Frame settings the remote side believes are active
    uart_cfg_t   model_cfg;

    cfg_link_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) cfg_link_top_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .tx_ready_i  (tx_ready_i),
        .tx_valid_o  (tx_valid_o),
        .tx_data_o   (tx_data_o),
        .rx_valid_i  (rx_valid_i),
        .rx_data_i   (rx_data_i),
        .rx_parity_i (rx_parity_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_rand_bit(output logic b);
        b      = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    // The marker nibble C sits above the field id and the option in the low bits
    function automatic logic [7:0] pkt_byte(logic [1:0] id, logic [1:0] opt);
        return {4'hC, id, opt};
    endfunction

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        value_errs++;
        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic report_failure(input string msg);
        other_errs++;
        $display("ERROR: %s", msg);
    endtask

    // One classic cycle that stays on the bus through the edge that samples the ack
    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        int n;
        n        = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        do begin
            @(posedge clk_i);
            #10;
            n++;
        end while (!wb_ack_o && n < WB_LIMIT);
        rdat = wb_dat_o;
        if (wb_ack_o) begin
            // The cycle ends on the edge where the ack is high
            @(posedge clk_i);
            #10;
        end else begin
            report_failure("Wishbone cycle got no ack");
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [7:0] dat);
        wb_access(1'b0, adr, 8'h00, dat);
    endtask

    // Ready follows the LFSR, so the DUT sees random back-pressure
    task automatic expect_tx_byte(input logic [7:0] exp);
        int   n;
        logic rdy;
        logic sent;
        n    = 0;
        sent = 1'b0;
        while (!sent && n < TX_LIMIT) begin
            take_rand_bit(rdy);
            tx_ready_i = rdy;
            if (tx_valid_o && rdy) begin
                if (tx_data_o !== exp) begin
                    report_mismatch("tx_data_o", tx_data_o, exp);
                end
                sent = 1'b1;
            end
            @(posedge clk_i);
            #10;
            n++;
        end
        tx_ready_i = 1'b0;
        if (!sent) begin
            report_failure("expected transmit byte never arrived");
        end
    endtask

    // Parity bit covers the low data-width bits; bad inverts it
    task automatic send_rx_byte(input logic [7:0] data, input logic bad);
        logic par;
        case (model_cfg.data_width)
            DW_5BIT: par = ^data[4:0];
            DW_6BIT: par = ^data[5:0];
            DW_7BIT: par = ^data[6:0];
            default: par = ^data;
        endcase
        if (model_cfg.parity_mode == PAR_ODD) begin
            par = ~par;
        end
        rx_valid_i  = 1'b1;
        rx_data_i   = data;
        rx_parity_i = par ^ bad;
        @(posedge clk_i);
        #10;
        rx_valid_i  = 1'b0;
    endtask

    task automatic wait_status(input logic [2:0] idx);
        logic [7:0] st;
        int         n;
        n  = 0;
        st = 8'h00;
        while (!st[idx] && n < POLL_LIMIT) begin
            wb_read(REG_STATUS, st);
            n++;
        end
        if (!st[idx]) begin
            other_errs++;
            $display("ERROR: STATUS bit %0d was never set", idx);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic test_registers();
        logic [7:0] rd;
        wb_read(REG_CUR_CFG, rd);
        if (rd !== STD_BYTE) report_mismatch("CUR_CFG", rd, STD_BYTE);
        // Only bits 5:0 are stored
        wb_write(REG_NEW_CFG, 8'hDA);
        wb_read(REG_NEW_CFG, rd);
        if (rd !== 8'h1A) report_mismatch("NEW_CFG", rd, 8'h1A);
    endtask

    task automatic test_master_success();
        logic [7:0] rd;
        uart_cfg_t  cfg;
        cfg = '{data_width: DW_6BIT, parity_mode: PAR_ODD, stop_bits: 2'd2};
        wb_write(REG_NEW_CFG, {2'b00, cfg});
        wb_write(REG_CTRL, 8'h01);
        repeat (3) expect_tx_byte(SYN_BYTE);
        send_rx_byte(ACKN_BYTE, 1'b0);
        expect_tx_byte(pkt_byte(2'd0, cfg.data_width));
        send_rx_byte(ACKN_BYTE, 1'b0);
        expect_tx_byte(pkt_byte(2'd1, cfg.parity_mode));
        send_rx_byte(ACKN_BYTE, 1'b0);
        expect_tx_byte(pkt_byte(2'd2, cfg.stop_bits));
        send_rx_byte(ACKN_BYTE, 1'b0);
        expect_tx_byte(pkt_byte(2'd3, 2'b00));
        send_rx_byte(ACKN_BYTE, 1'b0);
        wait_status(3'd2);
        wb_read(REG_CUR_CFG, rd);
        if (rd !== {2'b00, cfg}) report_mismatch("CUR_CFG", rd, {2'b00, cfg});
        wb_read(REG_STATUS, rd);
        if (rd[0]) report_failure("configuration error after a good master run");
    endtask

    // Starts from the frame left by the master run, so the fallback must change it
    task automatic test_master_retries();
        logic [7:0] rd;
        wb_write(REG_STATUS, 8'h07);
        wb_write(REG_CTRL, 8'h01);
        repeat (9) expect_tx_byte(SYN_BYTE);
        wait_status(3'd0);
        if (tx_valid_o) report_failure("SYN still sent after the last attempt");
        wb_read(REG_CUR_CFG, rd);
        if (rd !== STD_BYTE) report_mismatch("CUR_CFG", rd, STD_BYTE);
    endtask

    task automatic test_slave_success();
        logic [7:0] rd;
        logic [7:0] exp;
        exp = {2'b00, DW_7BIT, PAR_EVEN, 2'd1};
        wb_write(REG_STATUS, 8'h07);
        wb_write(REG_CTRL, 8'h04);
        send_rx_byte(SYN_BYTE, 1'b0);
        expect_tx_byte(ACKN_BYTE);
        send_rx_byte(pkt_byte(2'd0, DW_7BIT), 1'b0);
        expect_tx_byte(ACKN_BYTE);
        send_rx_byte(pkt_byte(2'd1, PAR_EVEN), 1'b0);
        expect_tx_byte(ACKN_BYTE);
        send_rx_byte(pkt_byte(2'd2, 2'd1), 1'b0);
        expect_tx_byte(ACKN_BYTE);
        send_rx_byte(pkt_byte(2'd3, 2'd0), 1'b0);
        expect_tx_byte(ACKN_BYTE);
        wait_status(3'd2);
        wb_read(REG_CUR_CFG, rd);
        if (rd !== exp) report_mismatch("CUR_CFG", rd, exp);
        wb_read(REG_STATUS, rd);
        if (rd[0]) report_failure("configuration error after a good slave run");
        model_cfg = uart_cfg_t'(exp[5:0]);
    endtask

    // Runs under the 7-bit even setting left by the slave test
    task automatic test_parity();
        logic [7:0] rd;
        wb_write(REG_STATUS, 8'h07);
        send_rx_byte(8'h5A, 1'b0);
        send_rx_byte(8'h33, 1'b0);
        send_rx_byte(8'h7F, 1'b0);
        repeat (2) @(posedge clk_i);
        #10;
        wb_read(REG_STATUS, rd);
        if (rd[1]) report_failure("parity error flagged on good bytes");
        send_rx_byte(8'h4C, 1'b1);
        repeat (2) @(posedge clk_i);
        #10;
        wb_read(REG_STATUS, rd);
        if (!rd[1]) report_failure("bad parity bit was not flagged");
        wb_write(REG_STATUS, 8'h02);
        wb_read(REG_STATUS, rd);
        if (rd[1]) report_failure("parity error bit did not clear");
    endtask

    task automatic test_slave_timeout();
        logic [7:0] rd;
        wb_write(REG_STATUS, 8'h07);
        send_rx_byte(SYN_BYTE, 1'b0);
        expect_tx_byte(ACKN_BYTE);
        send_rx_byte(pkt_byte(2'd0, DW_5BIT), 1'b0);
        expect_tx_byte(ACKN_BYTE);
        wait_status(3'd0);
        wb_read(REG_CUR_CFG, rd);
        if (rd !== STD_BYTE) report_mismatch("CUR_CFG", rd, STD_BYTE);
        model_cfg = uart_cfg_t'(STD_BYTE[5:0]);
    endtask

    // A short slave run moves the frame away from the default first
    task automatic test_set_standard();
        logic [7:0] rd;
        logic [7:0] exp;
        exp = {2'b00, DW_5BIT, PAR_NONE, 2'b00};
        wb_write(REG_STATUS, 8'h07);
        send_rx_byte(SYN_BYTE, 1'b0);
        expect_tx_byte(ACKN_BYTE);
        send_rx_byte(pkt_byte(2'd0, DW_5BIT), 1'b0);
        expect_tx_byte(ACKN_BYTE);
        send_rx_byte(pkt_byte(2'd3, 2'd0), 1'b0);
        expect_tx_byte(ACKN_BYTE);
        wait_status(3'd2);
        wb_read(REG_CUR_CFG, rd);
        if (rd !== exp) report_mismatch("CUR_CFG", rd, exp);
        // Set-standard while idle puts the default frame back
        wb_write(REG_CTRL, 8'h02);
        wb_read(REG_CUR_CFG, rd);
        if (rd !== STD_BYTE) report_mismatch("CUR_CFG", rd, STD_BYTE);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        rst_n_i     = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = 2'b00;
        wb_dat_i    = 8'h00;
        tx_ready_i  = 1'b0;
        rx_valid_i  = 1'b0;
        rx_data_i   = 8'h00;
        rx_parity_i = 1'b0;
        value_errs  = 0;
        other_errs  = 0;
        lfsr_q      = 32'h887f;
        model_cfg   = uart_cfg_t'(STD_BYTE[5:0]);
        repeat (3) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;

        test_registers();
        test_master_success();
        test_master_retries();
        test_slave_success();
        test_parity();
        test_slave_timeout();
        test_set_standard();

        $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tb.f */
design/cfg_link_pkg.sv
design/cfg_ctrl_if.sv
design/cfg_regs.sv
design/cfg_link_fsm.sv
design/parity_checker.sv
design/cfg_link_top.sv
verif/cfg_link_checker.sv
verif/cfg_link_tb.sv

/* Makefile */
# Verilator flow for the link configuration controller

VERILATOR ?= verilator
TOP       ?= cfg_link_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o $(TOP)

# The run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
